//--- Bender.yml
package:
  name: uart_periph

sources:
  - include_dirs:
      - src
    files:
      - src/uart_pkg.sv
      - src/uart_tx.sv
      - src/uart_rx.sv
      - src/uart_wrapper.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/uart_checker.sv
      - tests/uart_tb.sv

//--- src/uart_config.svh
// ------------------------------
// UART configuration constants
// Divider width, reset baud divider and register map
// ------------------------------

`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// The baud divider is wide enough for 9600 baud at a 64 MHz clock
`define UART_DIV_W 13

// Reset divider gives 115200 baud at 64 MHz
`define UART_DIV_RESET 555

// Register offsets inside the peripheral window
`define UART_ADDR_DATA   6'h00  // TX byte on write, RX byte on read
`define UART_ADDR_STATUS 6'h04  // Bit 1 rx valid, bit 0 tx busy
`define UART_ADDR_DIV    6'h08  // Baud divider, cycles per serial bit

`endif

//--- src/uart_pkg.sv
// ------------------------------
// UART shared types
// Data, divider, bus and FSM state types
// ------------------------------

`default_nettype none

`include "uart_config.svh"

package uart_pkg;

    typedef logic [7:0] uart_byte_t;              // One serial data byte
    typedef logic [`UART_DIV_W-1:0] uart_div_t;   // Clock cycles per serial bit
    typedef logic [5:0] uart_addr_t;              // Register offset in the peripheral

    // Bus access size where 11 is idle, 00 byte, 01 halfword and 10 word
    typedef logic [1:0] bus_size_t;

    typedef enum logic [1:0] {
        tx_st_idle,   // Line held high, waiting for a start pulse
        tx_st_start,  // Driving the start bit
        tx_st_data,   // Shifting out eight data bits
        tx_st_stop    // Driving the stop bit
    } uart_tx_state_t;

    typedef enum logic [1:0] {
        rx_st_idle,   // Waiting for a falling edge
        rx_st_start,  // Re-checking the start bit at half a period
        rx_st_data,   // Sampling data bits at mid-bit
        rx_st_stop    // Sampling the stop bit
    } uart_rx_state_t;

endpackage

`default_nettype wire

//--- src/uart_rx.sv
// ------------------------------
// UART receiver
// Samples 8N1 frames mid-bit and holds one byte
// ------------------------------

`default_nettype none

module uart_rx (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  rxd,      // Asynchronous serial input
    input  wire                  read,     // Bus read of the data register
    input  wire uart_pkg::uart_div_t  divider,
    output uart_pkg::uart_byte_t rx_data,  // Held byte, meaningful while valid is high
    output logic                 valid,
    output logic                 rts       // High while the holding register is full
);

    import uart_pkg::*;

    logic           rxd_meta;  // First synchronizer stage
    logic           rxd_sync;  // Second stage, safe to use in logic
    logic           rxd_prev;  // Previous synchronized value for edge detection
    logic           fall;
    uart_rx_state_t state;
    uart_div_t      div_q;     // Bit period captured on the start edge
    uart_div_t      half_m1;   // Last count of the half-bit start check
    uart_div_t      bit_cnt;
    logic [2:0]     bit_idx;
    uart_byte_t     shift_q;   // Bits arrive LSB first and enter at the top
    logic           bit_end;
    logic           frame_ok;

    // Line idles high, so the synchronizer resets to a mark to avoid a false start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall    = rxd_prev & ~rxd_sync;
    assign half_m1 = (div_q >> 1) - 1'b1;

    // The start check lands at mid-bit, so full periods after it also land mid-bit
    assign bit_end = (state == rx_st_start) ? (bit_cnt == half_m1)
                                            : (bit_cnt == div_q - 1'b1);

    // Stop bit sampled high, so the frame is good
    assign frame_ok = (state == rx_st_stop) && bit_end && rxd_sync;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= rx_st_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            bit_cnt <= (state == rx_st_idle || bit_end) ? '0 : bit_cnt + 1'b1;
            case (state)
                rx_st_idle: if (fall) state <= rx_st_start;
                rx_st_start: begin
                    if (bit_end) begin
                        // A glitch shorter than half a bit goes back to idle
                        state   <= rxd_sync ? rx_st_idle : rx_st_data;
                        bit_idx <= '0;
                    end
                end
                rx_st_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= rx_st_stop;
                    end
                end
                rx_st_stop: if (bit_end) state <= rx_st_idle;  // Bad stop bits drop the frame
                default:    state <= rx_st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rx_st_idle && fall) div_q <= divider;  // Divider held for the frame
        if (state == rx_st_data && bit_end) shift_q <= {rxd_sync, shift_q[7:1]};
    end

    // A new byte only lands in an empty holding register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (frame_ok && !valid) begin
            valid <= 1'b1;  // A read in this same cycle does not clear it
        end else if (read) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_ok && !valid) rx_data <= shift_q;
    end

    assign rts = valid;

endmodule

`default_nettype wire

//--- src/uart_tx.sv
// ------------------------------
// UART transmitter
// Sends one 8N1 frame per start pulse, LSB first
// ------------------------------

`default_nettype none

module uart_tx (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start,    // One-cycle request to send tx_data
    input  wire uart_pkg::uart_byte_t tx_data,
    input  wire uart_pkg::uart_div_t  divider,
    output logic                 txd,      // Serial output, idles high
    output logic                 busy      // High from frame start to end of stop bit
);

    import uart_pkg::*;

    uart_tx_state_t state;
    uart_div_t      div_q;     // Bit period captured when the frame begins
    uart_div_t      bit_cnt;   // Cycles spent in the current bit
    logic [2:0]     bit_idx;   // Which data bit is on the line
    uart_byte_t     shift_q;   // Remaining data bits, LSB goes out next
    logic           bit_end;

    // Last cycle of the current bit period
    assign bit_end = (bit_cnt == div_q - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= tx_st_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                tx_st_idle: begin
                    bit_cnt <= '0;
                    if (start) state <= tx_st_start;  // Requests while busy never reach here
                end
                tx_st_start: begin
                    bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
                    if (bit_end) begin
                        state   <= tx_st_data;
                        bit_idx <= '0;
                    end
                end
                tx_st_data: begin
                    bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= tx_st_stop;  // Eighth bit just finished
                    end
                end
                tx_st_stop: begin
                    bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
                    if (bit_end) state <= tx_st_idle;  // Busy drops with this edge
                end
                default: state <= tx_st_idle;
            endcase
        end
    end

    // The byte and the bit period are frozen for the whole frame
    always_ff @(posedge clk) begin
        if (state == tx_st_idle && start) begin
            div_q   <= divider;
            shift_q <= tx_data;
        end else if (state == tx_st_data && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};  // Next data bit moves to position 0
        end
    end

    always_comb begin
        case (state)
            tx_st_start: txd = 1'b0;
            tx_st_data:  txd = shift_q[0];
            default:     txd = 1'b1;  // Idle and stop bit both drive a mark
        endcase
    end

    assign busy = (state != tx_st_idle);

endmodule

`default_nettype wire

//--- src/uart_wrapper.sv
// ------------------------------
// UART peripheral top level
// Bus registers around the transmitter and receiver
// ------------------------------

`default_nettype none

`include "uart_config.svh"

module uart_wrapper (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire [7:0]              ui_in,         // ui_in[7] carries the serial input
    output logic [7:0]             uo_out,        // uo_out[0] txd, uo_out[1] rts
    input  wire uart_pkg::uart_addr_t address,
    input  wire [31:0]             data_in,       // Low 8, 16 or 32 bits valid on a write
    input  wire uart_pkg::bus_size_t  data_write_n,
    input  wire uart_pkg::bus_size_t  data_read_n,
    output logic [31:0]            data_out,
    output logic                   data_ready,
    output logic [1:0]             user_interrupt
);

    import uart_pkg::*;

    logic       wr_en;      // Any write size this cycle
    logic       wr_wide;    // Halfword or word write
    logic       rd_en;
    logic       tx_start;
    logic       rx_read;
    uart_div_t  div_q;      // Programmed cycles per serial bit
    logic       txd;
    logic       tx_busy;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       rts;

    assign wr_en   = (data_write_n != 2'b11);
    assign wr_wide = (data_write_n == 2'b01) || (data_write_n == 2'b10);
    assign rd_en   = (data_read_n != 2'b11);

    // Writes to the data register start a frame, reads pop the held byte
    assign tx_start = wr_en && (address == `UART_ADDR_DATA);
    assign rx_read  = rd_en && (address == `UART_ADDR_DATA);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_q <= uart_div_t'(`UART_DIV_RESET);
        end else if (address == `UART_ADDR_DIV) begin
            if (wr_en)   div_q[7:0] <= data_in[7:0];  // Byte writes touch only the low part
            if (wr_wide) div_q[`UART_DIV_W-1:8] <= data_in[`UART_DIV_W-1:8];
        end
    end

    uart_tx i_uart_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (tx_start),
        .tx_data (data_in[7:0]),
        .divider (div_q),
        .txd     (txd),
        .busy    (tx_busy)
    );

    uart_rx i_uart_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .rxd     (ui_in[7]),
        .read    (rx_read),
        .divider (div_q),
        .rx_data (rx_data),
        .valid   (rx_valid),
        .rts     (rts)
    );

    // Read data depends only on the address, so every read finishes in one cycle
    always_comb begin
        case (address)
            `UART_ADDR_DATA:   data_out = {24'd0, rx_data};
            `UART_ADDR_STATUS: data_out = {30'd0, rx_valid, tx_busy};
            `UART_ADDR_DIV:    data_out = {{(32 - `UART_DIV_W){1'b0}}, div_q};
            default:           data_out = 32'd0;
        endcase
    end

    assign data_ready = 1'b1;

    // Interrupt 1 says a byte can be sent, interrupt 0 says one has arrived
    assign user_interrupt = {~tx_busy, rx_valid};

    assign uo_out = {6'd0, rts, txd};  // Upper pins are not used by this peripheral

endmodule

`default_nettype wire

//--- tests/uart_checker.sv
// ------------------------------
// UART checker
// Models the peripheral from its ports and compares
// ------------------------------

`default_nettype none

`include "uart_config.svh"

module uart_checker (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire [7:0]                 ui_in,
    input  wire [7:0]                 uo_out,
    input  wire uart_pkg::uart_addr_t address,
    input  wire [31:0]                data_in,
    input  wire uart_pkg::bus_size_t  data_write_n,
    input  wire uart_pkg::bus_size_t  data_read_n,
    input  wire [31:0]                data_out,
    input  wire                       data_ready,
    input  wire [1:0]                 user_interrupt,
    output int                        errors,
    output int                        tx_pending  // Written bytes not yet seen on the line
);
    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    uart_div_t   div_m;       // Modeled divider register
    logic        busy_m;
    logic        valid_m;
    uart_byte_t  held_m;      // Modeled holding register
    uart_byte_t  tx_q[$];     // Bytes the transmitter accepted, oldest first
    int          busy_cnt;    // Cycles left in the current TX frame
    int          frame_div;   // Bit period of the current TX frame
    int          tx_cnt;      // Samples since the TX start bit, -1 when idle
    int          rx_cnt;      // Samples since the RX start edge, -1 when idle
    int          rx_div;
    int          k;
    uart_byte_t  tx_byte;
    uart_byte_t  rx_byte;
    uart_byte_t  exp_b;
    logic        rx_ok;
    logic        txd_prev;
    logic        rxd_prev;
    logic        wr;
    logic        rd;
    logic [31:0] exp_rd;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail %s at %0t: expected %h, got %h", name, $time, exp, act);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    initial errors = 0;

    // Everything is sampled at the rising edge, before the DUT registers move
    always @(posedge clk) begin
        wr = (data_write_n != 2'b11);
        rd = (data_read_n != 2'b11);
        if (!rst_n) begin
            div_m     <= uart_div_t'(`UART_DIV_RESET);
            busy_m    <= 1'b0;
            valid_m   <= 1'b0;
            frame_div = `UART_DIV_RESET;
            tx_cnt    = -1;
            rx_cnt    = -1;
            txd_prev  = 1'b1;
            rxd_prev  = 1'b1;
        end else begin
            if (data_ready !== 1'b1) report_mismatch("data_ready", 1, data_ready);
            if (uo_out[7:2] !== 6'd0) report_mismatch("uo_out[7:2]", 0, uo_out[7:2]);
            if (uo_out[1] !== valid_m) report_mismatch("uo_out[1]", valid_m, uo_out[1]);
            if (user_interrupt !== {~busy_m, valid_m})
                report_mismatch("user_interrupt", {~busy_m, valid_m}, user_interrupt);
            if (!busy_m && uo_out[0] !== 1'b1) report_mismatch("uo_out[0]", 1, uo_out[0]);
            if (rd) begin
                case (address)
                    `UART_ADDR_DATA:   exp_rd = {24'd0, held_m};
                    `UART_ADDR_STATUS: exp_rd = {30'd0, valid_m, busy_m};
                    `UART_ADDR_DIV:    exp_rd = 32'(div_m);
                    default:           exp_rd = 32'd0;
                endcase
                // The held byte means nothing until a frame has landed
                if ((address != `UART_ADDR_DATA || valid_m) && data_out !== exp_rd)
                    report_mismatch("data_out", exp_rd, data_out);
            end
            if (wr && address == `UART_ADDR_DIV) begin
                div_m[7:0] <= data_in[7:0];
                if (data_write_n != 2'b00) div_m[`UART_DIV_W-1:8] <= data_in[`UART_DIV_W-1:8];
            end
            // A frame is ten bit periods long
            if (busy_m) begin
                busy_cnt = busy_cnt - 1;
                if (busy_cnt == 0) busy_m <= 1'b0;
            end else if (wr && address == `UART_ADDR_DATA) begin
                busy_m    <= 1'b1;
                busy_cnt  = 10 * div_m;
                frame_div = div_m;
                tx_q.push_back(data_in[7:0]);
            end
            // Bit k of the TX frame is sampled in its middle
            if (tx_cnt >= 0) tx_cnt++;
            else if (txd_prev && uo_out[0] === 1'b0) tx_cnt = 0;
            if (tx_cnt >= 0 && tx_cnt % frame_div == frame_div / 2) begin
                k = tx_cnt / frame_div;
                if (k >= 1 && k <= 8) tx_byte[k-1] = uo_out[0];  // LSB first
                if (k == 9) begin
                    tx_cnt = -1;
                    if (uo_out[0] !== 1'b1) report_problem("stop bit on uo_out[0] was low");
                    if (tx_q.size() == 0) begin
                        report_problem("a frame on uo_out[0] had no byte written for it");
                    end else begin
                        exp_b = tx_q.pop_front();
                        if (tx_byte !== exp_b) report_mismatch("uo_out[0] byte", exp_b, tx_byte);
                    end
                end
            end
            txd_prev = uo_out[0];
            // The RX synchronizer and edge detect add two cycles
            if (rx_cnt >= 0) rx_cnt++;
            else if (rxd_prev && ui_in[7] === 1'b0) begin
                rx_cnt = 0;
                rx_div = div_m;
            end
            if (rx_cnt >= 1 + rx_div / 2 && (rx_cnt - 1 - rx_div / 2) % rx_div == 0) begin
                k = (rx_cnt - 1 - rx_div / 2) / rx_div;
                if (k == 0 && ui_in[7]) rx_cnt = -1;  // Start bit did not hold
                if (k >= 1 && k <= 8) rx_byte[k-1] = ui_in[7];
                if (k == 9) rx_ok = ui_in[7];
            end
            if (rx_cnt == 2 + rx_div / 2 + 9 * rx_div && rx_ok && !valid_m) begin
                rx_cnt = -1;
                valid_m <= 1'b1;  // Wins over a read in the same cycle
                held_m  <= rx_byte;
            end else begin
                if (rx_cnt == 2 + rx_div / 2 + 9 * rx_div) rx_cnt = -1;
                if (rd && address == `UART_ADDR_DATA) valid_m <= 1'b0;
            end
            rxd_prev = ui_in[7];
        end
        tx_pending = tx_q.size();
    end

endmodule

`default_nettype wire

//--- tests/uart_tb.sv
// ------------------------------
// UART testbench
// Seeded random bus and serial traffic
// ------------------------------

`default_nettype none

`include "uart_config.svh"

module uart_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    localparam int POLL_LIMIT = 4000;  // Iterations allowed for any single wait

    logic        clk;
    logic        rst_n;
    logic [7:0]  ui_in;
    logic [7:0]  uo_out;
    uart_addr_t  address;
    logic [31:0] data_in;
    bus_size_t   data_write_n;
    bus_size_t   data_read_n;
    logic [31:0] data_out;
    logic        data_ready;
    logic [1:0]  user_interrupt;
    int          errors;      // Counted by the checker
    int          tx_pending;
    int          tb_errors;   // Timeouts and leftovers
    integer      seed;
    int          div;         // Programmed bit period
    logic [31:0] rd_val;
    uart_byte_t  rx_b;
    logic        stop_ok;
    logic        mid_read;

    uart_wrapper i_dut (.*);

    uart_checker i_checker (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic bus_write(input uart_addr_t addr, input logic [31:0] data,
                             input bus_size_t size);
        @(negedge clk);
        address      = addr;
        data_in      = data;
        data_write_n = size;
        @(negedge clk);
        data_write_n = 2'b11;
    endtask

    task automatic bus_read(input uart_addr_t addr, output logic [31:0] value);
        @(negedge clk);
        address     = addr;
        data_read_n = 2'b10;
        @(posedge clk);
        value = data_out;  // Settled since the falling edge
        @(negedge clk);
        data_read_n = 2'b11;
    endtask

    task automatic wait_tx_idle();
        int n;
        logic [31:0] st;
        n  = 0;
        st = 32'd1;
        while (st[0] && n < POLL_LIMIT) begin
            bus_read(`UART_ADDR_STATUS, st);
            n++;
        end
        if (st[0]) begin
            $display("Error at %0t: transmitter still busy after %0d polls", $time, n);
            tb_errors++;
        end
    endtask

    task automatic wait_rx_valid();
        int n;
        n = 0;
        while (uo_out[1] !== 1'b1 && n < POLL_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (uo_out[1] !== 1'b1) begin
            $display("Error at %0t: no received byte became valid", $time);
            tb_errors++;
        end
    endtask

    // One 8N1 frame on ui_in[7], then two idle bit periods
    task automatic send_frame(input uart_byte_t data, input logic stop);
        logic [9:0] bits;
        bits = {stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            ui_in[7] = bits[i];
            repeat (div - 1) @(negedge clk);
        end
        @(negedge clk);
        ui_in[7] = 1'b1;
        repeat (2 * div) @(negedge clk);
    endtask

    initial begin
        seed         = 32'h2b7d_fc09;
        tb_errors    = 0;
        rst_n        = 1'b0;
        ui_in        = 8'h80;  // Serial line idles high
        address      = '0;
        data_in      = '0;
        data_write_n = 2'b11;
        data_read_n  = 2'b11;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        bus_read(`UART_ADDR_DIV, rd_val);
        bus_read(`UART_ADDR_STATUS, rd_val);
        bus_write(`UART_ADDR_DIV, $random(seed), 2'b00);  // Low byte only
        bus_read(`UART_ADDR_DIV, rd_val);
        bus_write(`UART_ADDR_DIV, $random(seed), 2'b01);
        bus_read(`UART_ADDR_DIV, rd_val);
        bus_read(6'h0c, rd_val);
        bus_read(6'h3c, rd_val);
        div = 8 + $unsigned($random(seed)) % 13;
        bus_write(`UART_ADDR_DIV, div, 2'b10);
        bus_read(`UART_ADDR_DIV, rd_val);

        repeat (6) begin
            wait_tx_idle();
            bus_write(`UART_ADDR_DATA, $random(seed), 2'b00);
            if ($random(seed) & 1) bus_write(`UART_ADDR_DATA, $random(seed), 2'b00);
        end
        wait_tx_idle();

        repeat (10) begin
            rx_b     = $random(seed);
            stop_ok  = ($random(seed) & 3) != 0;  // One frame in four has a bad stop bit
            mid_read = $random(seed) & 1;
            fork
                send_frame(rx_b, stop_ok);
                if (mid_read) begin
                    repeat ($unsigned($random(seed)) % (12 * div)) @(negedge clk);
                    bus_read(`UART_ADDR_DATA, rd_val);
                end
            join
            if (stop_ok && !mid_read && ($random(seed) & 1)) begin
                wait_rx_valid();
                bus_read(`UART_ADDR_DATA, rd_val);
            end
        end

        repeat (4) @(negedge clk);
        if (tx_pending != 0) begin
            $display("Error: %0d written bytes never appeared on uo_out[0]", tx_pending);
            tb_errors++;
        end
        $display("Checker errors: %0d, testbench errors: %0d", errors, tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_wrapper.sv
tests/uart_checker.sv
tests/uart_tb.sv
